// File: all.f
logic/l1d_pkg.sv
logic/l1_ld_mem.sv
logic/l1_dm_mem.sv
logic/l1_lrum.sv
logic/l1d_top.sv
test/l1d_checker.sv
test/tb_l1d.sv

// File: run.sh
#!/bin/sh
# Build and run the L1 data cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_l1d -f all.f -o sim_l1d

./obj_dir/sim_l1d > sim.log 2>&1 || true
cat sim.log

if grep -q "TB PASSED" sim.log; then
	exit 0
fi
exit 1

// File: test/tb_l1d.sv
// Testbench for the L1 data cache.
// Generates clock and reset, models the MAU with a word memory and a
// random ack delay, and applies a table of core requests one at a time.
// All comparing is done in l1d_checker; this module reports the result.

module tb_l1d;
	import l1d_pkg::*;

	localparam int WAY_NUM = 4;
	localparam int SET_NUM = 16;
	localparam logic [31:0] SEED = 32'hb5df_6400;

	typedef struct packed {
		core_cop_t  cop;
		core_addr_t addr;
		core_size_t size;
		core_data_t wdata;
	} step_t;

	logic       clk;
	logic       rst_n;
	logic       core_req_val;
	core_req_t  core_req;
	logic       core_req_ack;
	core_data_t core_ack_data;
	logic       cache_ready;
	logic       mau_req_val;
	mau_req_t   mau_req;
	logic       mau_req_ack;
	logic       mau_ack_nc;
	l1_line_t   mau_ack_data;
	int         err_count;
	int         test_count;
	int         total_errs;

	step_t      steps [$];
	core_data_t mem [core_addr_t];
	int         cycles;
	int         limit;

	l1d_top #(.WAY_NUM(WAY_NUM), .SET_NUM(SET_NUM)) uut (
		.clk(clk), .rst_n(rst_n),
		.core_req_val(core_req_val), .core_req(core_req),
		.core_req_ack(core_req_ack), .core_ack_data(core_ack_data),
		.cache_ready(cache_ready),
		.mau_req_val(mau_req_val), .mau_req(mau_req),
		.mau_req_ack(mau_req_ack), .mau_ack_nc(mau_ack_nc),
		.mau_ack_data(mau_ack_data)
	);

	l1d_checker #(.SET_NUM(SET_NUM), .WAY_NUM(WAY_NUM), .SEED(SEED)) chk (
		.clk(clk), .rst_n(rst_n),
		.core_req_val(core_req_val), .core_req(core_req),
		.core_req_ack(core_req_ack), .core_ack_data(core_ack_data),
		.cache_ready(cache_ready),
		.mau_req_val(mau_req_val), .mau_req(mau_req),
		.mau_req_ack(mau_req_ack),
		.err_count(err_count), .test_count(test_count)
	);

	always #20 clk = ~clk;

	// Initial memory contents, a mix of every address bit
	function automatic core_data_t initial_word(core_addr_t a);
		return ((a ^ SEED) * 32'h9e37_79b9) + {a[15:0], a[31:16]};
	endfunction

	function automatic core_data_t read_word(core_addr_t a);
		if (mem.exists(a))
			return mem[a];
		return initial_word(a);
	endfunction

	task automatic add_step(core_cop_t cop, core_addr_t addr, core_size_t size,
		core_data_t wdata);
		step_t s;
		s.cop   = cop;
		s.addr  = addr;
		s.size  = size;
		s.wdata = wdata;
		steps.push_back(s);
	endtask

	// ------------------------------------------------------------------
	// MAU model
	// ------------------------------------------------------------------
	task automatic serve_mau();
		mau_req_t   r;
		core_data_t w;
		int         delay;
		r     = mau_req;
		delay = int'($urandom % 4) + 1;
		repeat (delay) @(posedge clk);
		#2;
		mau_ack_data = '0;
		if (r.we) begin
			w = read_word(r.addr);
			for (int b = 0; b < 4; b++) begin
				if (r.be[b])
					w[b*8 +: 8] = r.wdata[b*8 +: 8];
			end
			mem[r.addr] = w;
			mau_ack_nc = 1'b1;
		end else if (r.nc) begin
			mau_ack_data[31:0] = read_word(r.addr);
			mau_ack_nc = 1'b1;
		end else begin
			for (int i = 0; i < 4; i++)
				mau_ack_data[i*32 +: 32] = read_word(r.addr + core_addr_t'(i * 4));
			mau_ack_nc = 1'b0;
		end
		mau_req_ack = 1'b1;
		@(posedge clk);
		#2;
		mau_req_ack = 1'b0;
	endtask

	always begin
		@(negedge clk);
		if (rst_n && mau_req_val)
			serve_mau();
	end

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("Timeout: no core_req_ack after %0d cycles", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		core_req_val = 1'b0;
		core_req     = '0;
		mau_req_ack  = 1'b0;
		mau_ack_nc   = 1'b0;
		mau_ack_data = '0;
		cycles       = 0;
		limit        = 0;
		void'($urandom(SEED));

		// Miss, hit, write hit, forwarding
		add_step(CORE_REQ_RD,   32'h0000_0100, 3'd4, 32'h0);
		add_step(CORE_REQ_RD,   32'h0000_0108, 3'd4, 32'h0);
		add_step(CORE_REQ_WR,   32'h0000_0108, 3'd4, 32'hdead_beef);
		add_step(CORE_REQ_RD,   32'h0000_0108, 3'd4, 32'h0);
		add_step(CORE_REQ_WR,   32'h0000_0104, 3'd1, 32'h1234_56a5);
		add_step(CORE_REQ_RD,   32'h0000_0104, 3'd4, 32'h0);
		add_step(CORE_REQ_RD,   32'h0000_010c, 3'd4, 32'h0);
		add_step(CORE_REQ_RD,   32'h0000_0100, 3'd4, 32'h0);
		// Write miss does not allocate
		add_step(CORE_REQ_WR,   32'h0000_0208, 3'd2, 32'hffff_c3c3);
		add_step(CORE_REQ_RD,   32'h0000_0208, 3'd4, 32'h0);
		// Non-cacheable traffic
		add_step(CORE_REQ_RDNC, 32'h0000_0300, 3'd4, 32'h0);
		add_step(CORE_REQ_RD,   32'h0000_0304, 3'd4, 32'h0);
		add_step(CORE_REQ_WRNC, 32'h0000_0300, 3'd4, 32'h0bad_f00d);
		add_step(CORE_REQ_RDNC, 32'h0000_0300, 3'd4, 32'h0);
		add_step(CORE_REQ_RD,   32'h0000_0300, 3'd4, 32'h0);
		// Five tags in set 3
		add_step(CORE_REQ_RD,   32'h0000_1030, 3'd4, 32'h0);
		add_step(CORE_REQ_RD,   32'h0000_2030, 3'd4, 32'h0);
		add_step(CORE_REQ_RD,   32'h0000_3030, 3'd4, 32'h0);
		add_step(CORE_REQ_RD,   32'h0000_4030, 3'd4, 32'h0);
		add_step(CORE_REQ_RD,   32'h0000_1034, 3'd4, 32'h0);
		add_step(CORE_REQ_RD,   32'h0000_5030, 3'd4, 32'h0);
		add_step(CORE_REQ_RD,   32'h0000_1038, 3'd4, 32'h0);
		add_step(CORE_REQ_RD,   32'h0000_2030, 3'd4, 32'h0);
		add_step(CORE_REQ_RD,   32'h0000_4030, 3'd4, 32'h0);
		add_step(CORE_REQ_RD,   32'h0000_3030, 3'd4, 32'h0);
		add_step(CORE_REQ_WR,   32'h0000_4034, 3'd4, 32'h5a5a_0f0f);
		add_step(CORE_REQ_RD,   32'h0000_4034, 3'd4, 32'h0);
		limit = steps.size() * 8 + SET_NUM + 64;

		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		while (!cache_ready)
			@(negedge clk);
		@(posedge clk);
		#2;

		foreach (steps[i]) begin
			core_req_val = 1'b1;
			core_req = '{addr: steps[i].addr, cop: steps[i].cop,
				wdata: steps[i].wdata, size: steps[i].size};
			do
				@(negedge clk);
			while (!core_req_ack);
			@(posedge clk);
			#2;
			core_req_val = 1'b0;
		end

		repeat (4) @(posedge clk);
		total_errs = err_count;
		if (test_count != steps.size()) begin
			$display("Only %0d of %0d tests completed", test_count, steps.size());
			total_errs = total_errs + 1;
		end
		$display("Tests: %0d  errors: %0d", test_count, total_errs);
		if (total_errs == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: test/l1d_checker.sv
// Result checker for the L1 data cache testbench.
// Samples the DUT ports on the falling clock edge, keeps a shadow copy
// of memory and of the LRU order of each set, and predicts read data
// and MAU traffic for every core request. Prints one line per test.

module l1d_checker
	import l1d_pkg::*;
#(
	parameter int          SET_NUM = 16,
	parameter int          WAY_NUM = 4,
	parameter logic [31:0] SEED    = 32'h0
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       core_req_val,
	input  core_req_t  core_req,
	input  logic       core_req_ack,
	input  core_data_t core_ack_data,
	input  logic       cache_ready,
	input  logic       mau_req_val,
	input  mau_req_t   mau_req,
	input  logic       mau_req_ack,
	output int         err_count,
	output int         test_count
);

	core_data_t  shadow [core_addr_t];
	logic [27:0] lru_line [SET_NUM][WAY_NUM];
	int          lru_cnt [SET_NUM];
	logic        ready_seen;
	int          low_cycles;
	logic        active;
	core_req_t   cur;
	int          exp_mau;
	int          mau_seen;
	core_data_t  exp_data;
	logic        last_wr_val;
	core_addr_t  last_wr_addr;
	logic        last_wr_full;

	function automatic core_data_t initial_word(core_addr_t a);
		return ((a ^ SEED) * 32'h9e37_79b9) + {a[15:0], a[31:16]};
	endfunction

	function automatic core_be_t be_of_size(core_size_t s);
		if (s == 3'd1)
			return 4'b0001;
		if (s == 3'd2)
			return 4'b0011;
		return 4'b1111;
	endfunction

	function automatic core_data_t shadow_word(core_addr_t a);
		if (shadow.exists(a))
			return shadow[a];
		return initial_word(a);
	endfunction

	// True LRU: index 0 newest; returns 1 on hit
	task automatic touch_line(input logic [27:0] line, output logic hit);
		int s;
		int pos;
		s   = int'(line[3:0]);
		pos = -1;
		for (int i = 0; i < lru_cnt[s]; i++) begin
			if (lru_line[s][i] == line)
				pos = i;
		end
		hit = (pos >= 0);
		if (!hit) begin
			pos = (lru_cnt[s] < WAY_NUM) ? lru_cnt[s] : WAY_NUM - 1;
			if (lru_cnt[s] < WAY_NUM)
				lru_cnt[s]++;
		end
		for (int i = pos; i > 0; i--)
			lru_line[s][i] = lru_line[s][i-1];
		lru_line[s][0] = line;
	endtask

	task automatic error(string what);
		$display("ERROR at %0t: %s", $time, what);
		err_count++;
	endtask

	task automatic start_test();
		logic       hit;
		core_be_t   be;
		core_data_t w;
		cur      = core_req;
		active   = 1'b1;
		mau_seen = 0;
		exp_mau  = 1;
		exp_data = shadow_word(cur.addr);
		if (cur.cop == CORE_REQ_RD) begin
			if (last_wr_val && last_wr_full && last_wr_addr[31:2] == cur.addr[31:2]) begin
				exp_mau = 0;
			end else begin
				touch_line(cur.addr[31:4], hit);
				exp_mau = hit ? 0 : 1;
			end
		end else if (cur.cop == CORE_REQ_WR || cur.cop == CORE_REQ_WRNC) begin
			be = be_of_size(cur.size);
			w  = exp_data;
			for (int b = 0; b < 4; b++) begin
				if (be[b])
					w[b*8 +: 8] = cur.wdata[b*8 +: 8];
			end
			shadow[cur.addr] = w;
			last_wr_val  = 1'b1;
			last_wr_addr = cur.addr;
			last_wr_full = (be == 4'b1111);
		end
	endtask

	task automatic check_mau();
		logic       nc;
		logic       we;
		core_addr_t a;
		mau_seen++;
		if (!active) begin
			error("MAU request with no core request outstanding");
			return;
		end
		nc = (cur.cop == CORE_REQ_RDNC) || (cur.cop == CORE_REQ_WRNC);
		we = (cur.cop == CORE_REQ_WR) || (cur.cop == CORE_REQ_WRNC);
		a  = (cur.cop == CORE_REQ_RD) ? {cur.addr[31:4], 4'h0} : cur.addr;
		if (mau_req.nc != nc) begin
			$display("MISMATCH t=%0t mau_req.nc exp %b got %b", $time, nc, mau_req.nc);
			err_count++;
		end
		if (mau_req.we != we) begin
			$display("MISMATCH t=%0t mau_req.we exp %b got %b", $time, we, mau_req.we);
			err_count++;
		end
		if (mau_req.addr != a) begin
			$display("MISMATCH t=%0t mau_req.addr exp %h got %h", $time, a, mau_req.addr);
			err_count++;
		end
		if (we && mau_req.be != be_of_size(cur.size)) begin
			$display("MISMATCH t=%0t mau_req.be exp %b got %b", $time,
				be_of_size(cur.size), mau_req.be);
			err_count++;
		end
		if (we && mau_req.wdata != cur.wdata) begin
			$display("MISMATCH t=%0t mau_req.wdata exp %h got %h", $time,
				cur.wdata, mau_req.wdata);
			err_count++;
		end
	endtask

	task automatic finish_test();
		int errs_before;
		errs_before = err_count;
		if (!active) begin
			error("core_req_ack without a request");
			return;
		end
		if (mau_seen != exp_mau) begin
			$display("MISMATCH t=%0t mau_requests exp %0d got %0d", $time, exp_mau, mau_seen);
			err_count++;
		end
		if ((cur.cop == CORE_REQ_RD || cur.cop == CORE_REQ_RDNC) && core_ack_data != exp_data) begin
			$display("MISMATCH t=%0t core_ack_data exp %h got %h", $time,
				exp_data, core_ack_data);
			err_count++;
		end
		$display("test %0d cop %0d addr %h mau %0d %s", test_count, cur.cop, cur.addr,
			mau_seen, (err_count == errs_before) ? "ok" : "bad");
		test_count++;
		active = 1'b0;
	endtask

	initial begin
		err_count   = 0;
		test_count  = 0;
		ready_seen  = 1'b0;
		low_cycles  = 0;
		active      = 1'b0;
		last_wr_val = 1'b0;
		foreach (lru_cnt[s])
			lru_cnt[s] = 0;
	end

	always @(negedge clk) begin
		if (!rst_n) begin
			low_cycles = 0;
		end else if (!ready_seen) begin
			if (mau_req_val || core_req_ack)
				error("MAU request or core ack before cache_ready");
			if (cache_ready) begin
				ready_seen = 1'b1;
				if (low_cycles != SET_NUM) begin
					$display("MISMATCH t=%0t cache_ready_delay exp %0d got %0d", $time,
						SET_NUM, low_cycles);
					err_count++;
				end
			end else begin
				low_cycles++;
			end
		end else begin
			if (core_req_val && !active)
				start_test();
			if (mau_req_val && mau_req_ack)
				check_mau();
			if (core_req_ack)
				finish_test();
		end
	end

endmodule

// File: logic/l1d_top.sv
// L1 data cache: write-through, no-write-allocate, set-associative.
// The core holds one request until core_req_ack. Tags and data of all
// ways are read in the request cycle and resolved the next cycle.
// Misses fetch a line from the MAU, writes and non-cacheable reads go
// out as single words. The last write stays in a delayed buffer that
// updates the hit way when the data array is idle and forwards to reads.

module l1d_top
	import l1d_pkg::*;
#(
	parameter int WAY_NUM = 4,
	parameter int SET_NUM = 16
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        core_req_val,
	input  core_req_t   core_req,
	output logic        core_req_ack,
	output core_data_t  core_ack_data,
	output logic        cache_ready,
	output logic        mau_req_val,
	output mau_req_t    mau_req,
	input  logic        mau_req_ack,
	input  logic        mau_ack_nc,
	input  l1_line_t    mau_ack_data
);

	localparam int IDX_W = $clog2(SET_NUM);
	localparam int LINE_WORDS = L1_LINE_WIDTH / CORE_DATA_WIDTH;

	function automatic core_data_t merge_word(core_data_t upd, core_data_t base, core_be_t be);
		core_data_t res;
		res = base;
		for (int b = 0; b < CORE_BE_WIDTH; b++) begin
			if (be[b])
				res[b*8 +: 8] = upd[b*8 +: 8];
		end
		return res;
	endfunction

	// Request
	logic               busy_r;
	logic               req_val;
	logic               req_val_r;
	core_req_t          req_r;
	l1_tag_t            req_tag;
	logic [IDX_W-1:0]   req_idx;
	logic [IDX_W-1:0]   core_idx;
	logic               cur_rd;
	logic               cur_rdnc;
	logic               cur_wr;
	logic               req_rd;
	logic               req_rdnc;
	logic               req_wr;
	logic               read_done;

	// Delayed write buffer
	logic               del_val_r;
	logic               del_pend_r;
	core_addr_t         del_addr_r;
	core_data_t         del_data_r;
	core_be_t           del_be_r;
	logic [WAY_NUM-1:0] del_way_r;
	logic [IDX_W-1:0]   del_idx;
	l1_line_be_t        del_line_be;
	logic               fwd_now;
	logic               fwd_full_now;
	logic               fwd_r;
	logic               fwd_full_r;
	logic               drain;
	logic               drain_kill;

	// Tag memories and LRU
	l1_ld_entry_t       ld_rdata [WAY_NUM];
	logic [WAY_NUM-1:0] ld_ready_vect;
	logic [WAY_NUM-1:0] ld_en_vect;
	logic [WAY_NUM-1:0] ld_we_vect;
	logic [IDX_W-1:0]   ld_addr;
	l1_ld_entry_t       ld_wdata;
	logic [WAY_NUM-1:0] ld_val_vect;
	logic [WAY_NUM-1:0] tag_cmp_vect;
	logic [WAY_NUM-1:0] wr_hit_vect;
	logic               lru_req;
	logic               lru_ready;
	logic               lru_hit;
	logic [WAY_NUM-1:0] lru_way_vect;
	logic [WAY_NUM-1:0] lru_way_r;

	// Data memories
	logic               dm_rd;
	logic [WAY_NUM-1:0] dm_en_vect;
	logic [WAY_NUM-1:0] dm_we_vect;
	logic [IDX_W-1:0]   dm_addr;
	l1_line_t           dm_wdata;
	l1_line_be_t        dm_be;
	l1_line_t           dm_rdata [WAY_NUM];

	// MAU and return path
	logic               mau_pend_r;
	logic               fill_ack;
	logic               nc_ack;
	logic               fill_ack_r;
	l1_line_t           fill_line_r;
	l1_line_t           hit_line;
	l1_line_t           ret_line;
	core_data_t         line_word;

	assign cache_ready = (&ld_ready_vect) & lru_ready;

	// ------------------------------------------------------------------
	// Request capture
	// ------------------------------------------------------------------
	assign cur_rd   = (core_req.cop == CORE_REQ_RD);
	assign cur_rdnc = (core_req.cop == CORE_REQ_RDNC);
	assign cur_wr   = (core_req.cop == CORE_REQ_WR) | (core_req.cop == CORE_REQ_WRNC);
	assign req_rd   = (req_r.cop == CORE_REQ_RD);
	assign req_rdnc = (req_r.cop == CORE_REQ_RDNC);
	assign req_wr   = (req_r.cop == CORE_REQ_WR) | (req_r.cop == CORE_REQ_WRNC);

	// Only the first cycle of a held request starts a lookup
	assign req_val = core_req_val & ~busy_r;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_r    <= 1'b0;
			req_val_r <= 1'b0;
		end else begin
			busy_r    <= (busy_r | req_val) & ~core_req_ack;
			req_val_r <= req_val;
		end
	end

	always_ff @(posedge clk) begin
		if (req_val)
			req_r <= core_req;
	end

	assign core_idx = core_req.addr[L1_OFFSET_WIDTH +: IDX_W];
	assign req_idx  = req_r.addr[L1_OFFSET_WIDTH +: IDX_W];
	assign req_tag  = req_r.addr[CORE_ADDR_WIDTH-1 -: L1_TAG_WIDTH];

	// ------------------------------------------------------------------
	// Delayed write buffer
	// ------------------------------------------------------------------
	assign fwd_now = del_val_r & cur_rd &
		(del_addr_r[CORE_ADDR_WIDTH-1:2] == core_req.addr[CORE_ADDR_WIDTH-1:2]);
	assign fwd_full_now = fwd_now & (&del_be_r);

	always_ff @(posedge clk) begin
		if (req_val && cur_wr) begin
			del_addr_r <= core_req.addr;
			del_data_r <= core_req.wdata;
			del_be_r   <= core_size_be(core_req.size);
		end
		if (req_val_r && req_wr)
			del_way_r <= wr_hit_vect;
	end

	// Array update is pending only when the write hit a way
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			del_val_r  <= 1'b0;
			del_pend_r <= 1'b0;
			fwd_r      <= 1'b0;
			fwd_full_r <= 1'b0;
		end else begin
			if (req_val && cur_wr)
				del_val_r <= 1'b1;
			if (req_val_r && req_wr)
				del_pend_r <= |wr_hit_vect;
			else if (drain || drain_kill)
				del_pend_r <= 1'b0;
			if (req_val) begin
				fwd_r      <= fwd_now;
				fwd_full_r <= fwd_full_now;
			end
		end
	end

	assign del_idx     = del_addr_r[L1_OFFSET_WIDTH +: IDX_W];
	assign del_line_be = l1_line_be_t'(del_be_r) << {del_addr_r[L1_OFFSET_WIDTH-1:2], 2'b00};
	assign drain       = del_pend_r & ~dm_rd & ~fill_ack;
	// A fill replacing the buffered line makes the pending update stale
	assign drain_kill  = fill_ack & del_pend_r & (del_idx == req_idx) & (|(del_way_r & lru_way_r));

	// ------------------------------------------------------------------
	// Tag lookup and replacement
	// ------------------------------------------------------------------
	assign lru_req = req_val & cur_rd & ~fwd_full_now;

	always_ff @(posedge clk) begin
		if (req_val_r)
			lru_way_r <= lru_way_vect;
	end

	assign ld_en_vect  = {WAY_NUM{req_val & ~cur_rdnc}} | (lru_way_r & {WAY_NUM{fill_ack}});
	assign ld_we_vect  = lru_way_r & {WAY_NUM{fill_ack}};
	assign ld_addr     = req_val ? core_idx : req_idx;
	assign ld_wdata    = '{val: 1'b1, tag: req_tag};
	assign wr_hit_vect = tag_cmp_vect & ld_val_vect;

	l1_lrum #(
		.WAY_NUM (WAY_NUM),
		.SET_NUM (SET_NUM)
	) lrum (
		.clk          (clk),
		.rst_n        (rst_n),
		.req          (lru_req),
		.idx          (core_idx),
		.tag_cmp_vect (tag_cmp_vect),
		.ld_val_vect  (ld_val_vect),
		.ready        (lru_ready),
		.hit          (lru_hit),
		.evict_val    (),
		.way_vect     (lru_way_vect)
	);

	// ------------------------------------------------------------------
	// Data array access: lookup, then fill, then buffer drain
	// ------------------------------------------------------------------
	assign dm_rd = lru_req;

	always_comb begin
		dm_en_vect = '0;
		dm_we_vect = '0;
		dm_addr    = del_idx;
		dm_wdata   = {LINE_WORDS{del_data_r}};
		dm_be      = del_line_be;
		if (dm_rd) begin
			dm_en_vect = '1;
			dm_addr    = core_idx;
		end else if (fill_ack) begin
			dm_en_vect = lru_way_r;
			dm_we_vect = lru_way_r;
			dm_addr    = req_idx;
			dm_wdata   = mau_ack_data;
			dm_be      = '1;
		end else if (drain) begin
			dm_en_vect = del_way_r;
			dm_we_vect = del_way_r;
		end
	end

	for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
		assign ld_val_vect[w]  = ld_rdata[w].val;
		assign tag_cmp_vect[w] = (ld_rdata[w].tag == req_tag);

		l1_ld_mem #(
			.SET_NUM (SET_NUM)
		) ld_mem (
			.clk   (clk),
			.rst_n (rst_n),
			.en    (ld_en_vect[w]),
			.we    (ld_we_vect[w]),
			.addr  (ld_addr),
			.wdata (ld_wdata),
			.rdata (ld_rdata[w]),
			.ready (ld_ready_vect[w])
		);

		l1_dm_mem #(
			.SET_NUM (SET_NUM)
		) dm_mem (
			.clk   (clk),
			.en    (dm_en_vect[w]),
			.we    (dm_we_vect[w]),
			.addr  (dm_addr),
			.wdata (dm_wdata),
			.be    (dm_be),
			.rdata (dm_rdata[w])
		);
	end

	// ------------------------------------------------------------------
	// MAU requests
	// ------------------------------------------------------------------
	assign read_done = lru_hit | fwd_full_r;
	assign fill_ack  = mau_req_ack & ~mau_ack_nc;
	assign nc_ack    = mau_req_ack & mau_ack_nc;

	assign mau_req_val = (req_val_r & (req_wr | req_rdnc | (req_rd & ~read_done))) | mau_pend_r;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mau_pend_r <= 1'b0;
			fill_ack_r <= 1'b0;
		end else begin
			mau_pend_r <= mau_req_val & ~mau_req_ack;
			fill_ack_r <= fill_ack;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_ack)
			fill_line_r <= mau_ack_data;
	end

	// Cached reads fetch the whole line, everything else one word
	always_comb begin
		mau_req.nc    = (req_r.cop == CORE_REQ_RDNC) | (req_r.cop == CORE_REQ_WRNC);
		mau_req.we    = req_wr;
		mau_req.addr  = req_r.addr;
		mau_req.wdata = req_r.wdata;
		mau_req.be    = core_size_be(req_r.size);
		if (req_rd)
			mau_req.addr = {req_r.addr[CORE_ADDR_WIDTH-1:L1_OFFSET_WIDTH], {L1_OFFSET_WIDTH{1'b0}}};
	end

	// ------------------------------------------------------------------
	// Core response
	// ------------------------------------------------------------------
	always_comb begin
		hit_line = '0;
		for (int w = 0; w < WAY_NUM; w++)
			hit_line |= dm_rdata[w] & {L1_LINE_WIDTH{lru_way_vect[w]}};
	end

	assign ret_line  = fill_ack_r ? fill_line_r : hit_line;
	assign line_word = ret_line[{req_r.addr[L1_OFFSET_WIDTH-1:2], 5'b0} +: CORE_DATA_WIDTH];

	assign core_req_ack  = (req_val_r & req_rd & read_done) | nc_ack | fill_ack_r;
	assign core_ack_data = nc_ack ? mau_ack_data[CORE_DATA_WIDTH-1:0] :
		fwd_r ? merge_word(del_data_r, line_word, del_be_r) : line_word;

	// ------------------------------------------------------------------
	// Assertions
	// ------------------------------------------------------------------
	req_only_when_ready: assert property (
		@(posedge clk) disable iff (!rst_n) core_req_val |-> cache_ready
	) else $error("core request while cache not ready");

	req_word_aligned: assert property (
		@(posedge clk) disable iff (!rst_n) core_req_val |-> (core_req.addr[1:0] == 2'b00)
	) else $error("unaligned core address %h", core_req.addr);

	no_lookup_on_fill: assert property (
		@(posedge clk) disable iff (!rst_n) !(req_val && fill_ack)
	) else $error("new lookup in the same cycle as a line fill");

endmodule

// File: logic/l1_lrum.sv
// Replacement state and hit detection for the cache.
// On req the set index is captured. The next cycle the tag compare and
// valid vectors of that set are present, and hit plus a one-hot way_vect
// come out: the hit way, or else the victim. The chosen way becomes the
// most recently used one in that same cycle.

module l1_lrum
	import l1d_pkg::*;
#(
	parameter int WAY_NUM = 4,
	parameter int SET_NUM = 16
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       req,
	input  logic [$clog2(SET_NUM)-1:0] idx,
	input  logic [WAY_NUM-1:0]         tag_cmp_vect,
	input  logic [WAY_NUM-1:0]         ld_val_vect,
	output logic                       ready,
	output logic                       hit,
	output logic                       evict_val,
	output logic [WAY_NUM-1:0]         way_vect
);

	localparam int IDX_W = $clog2(SET_NUM);
	localparam int AGE_W = (WAY_NUM > 1) ? $clog2(WAY_NUM) : 1;

	// Age 0 is the newest way, WAY_NUM-1 the oldest
	logic [AGE_W-1:0]   age [SET_NUM][WAY_NUM];
	logic               req_r;
	logic [IDX_W-1:0]   idx_r;
	logic [WAY_NUM-1:0] hit_vect;
	logic [WAY_NUM-1:0] victim;
	logic               inv_found;
	logic [AGE_W-1:0]   touch_age;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_r <= 1'b0;
			ready <= 1'b0;
		end else begin
			req_r <= req;
			ready <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (req)
			idx_r <= idx;
	end

	assign hit_vect = tag_cmp_vect & ld_val_vect;
	assign hit      = req_r & (|hit_vect);

	// Victim: first invalid way, otherwise the oldest
	always_comb begin
		victim    = '0;
		inv_found = 1'b0;
		for (int w = 0; w < WAY_NUM; w++) begin
			if (!ld_val_vect[w] && !inv_found) begin
				victim[w] = 1'b1;
				inv_found = 1'b1;
			end
		end
		if (!inv_found) begin
			for (int w = 0; w < WAY_NUM; w++) begin
				if (age[idx_r][w] == AGE_W'(WAY_NUM - 1))
					victim[w] = 1'b1;
			end
		end
	end

	assign way_vect  = (|hit_vect) ? hit_vect : victim;
	assign evict_val = req_r & ~(|hit_vect) & ~inv_found;

	always_comb begin
		touch_age = '0;
		for (int w = 0; w < WAY_NUM; w++) begin
			if (way_vect[w])
				touch_age = age[idx_r][w];
		end
	end

	// Age update, reset puts the ways in index order
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int s = 0; s < SET_NUM; s++) begin
				for (int w = 0; w < WAY_NUM; w++)
					age[s][w] <= AGE_W'(w);
			end
		end else if (req_r) begin
			for (int w = 0; w < WAY_NUM; w++) begin
				if (way_vect[w])
					age[idx_r][w] <= '0;
				else if (age[idx_r][w] < touch_age)
					age[idx_r][w] <= age[idx_r][w] + 1'b1;
			end
		end
	end

	// A duplicate tag in the set or a broken age order shows up here
	way_vect_onehot: assert property (
		@(posedge clk) disable iff (!rst_n) req_r |-> $onehot(way_vect)
	) else $error("LRU way_vect is not one-hot");

endmodule

// File: logic/l1_dm_mem.sv
// Line data storage of one cache way.
// Writes are byte-granular under be; reads return the whole line one
// cycle after en with we low.

module l1_dm_mem
	import l1d_pkg::*;
#(
	parameter int SET_NUM = 16
) (
	input  logic                       clk,
	input  logic                       en,
	input  logic                       we,
	input  logic [$clog2(SET_NUM)-1:0] addr,
	input  l1_line_t                   wdata,
	input  l1_line_be_t                be,
	output l1_line_t                   rdata
);

	l1_line_t mem [SET_NUM];

	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				for (int b = 0; b < L1_LINE_BYTES; b++) begin
					if (be[b])
						mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
				end
			end else begin
				rdata <= mem[addr];
			end
		end
	end

endmodule

// File: logic/l1_ld_mem.sv
// Tag and valid storage of one cache way.
// After reset a sweep writes an invalid entry into every set, one per
// cycle, and ready stays low until the last set is cleared.
// Reads return the entry one cycle after en with we low.

module l1_ld_mem
	import l1d_pkg::*;
#(
	parameter int SET_NUM = 16
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       en,
	input  logic                       we,
	input  logic [$clog2(SET_NUM)-1:0] addr,
	input  l1_ld_entry_t               wdata,
	output l1_ld_entry_t               rdata,
	output logic                       ready
);

	localparam int IDX_W = $clog2(SET_NUM);

	l1_ld_entry_t mem [SET_NUM];
	logic [IDX_W-1:0] clr_idx;

	// Clearing sweep
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clr_idx <= '0;
			ready   <= 1'b0;
		end else if (!ready) begin
			clr_idx <= clr_idx + 1'b1;
			if (clr_idx == IDX_W'(SET_NUM - 1))
				ready <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!ready)
			mem[clr_idx] <= '0;
		else if (en && we)
			mem[addr] <= wdata;
	end

	// Read port, holds its value across writes
	always_ff @(posedge clk) begin
		if (en && !we)
			rdata <= mem[addr];
	end

	no_access_before_ready: assert property (
		@(posedge clk) disable iff (!rst_n) en |-> ready
	) else $error("tag memory accessed during clearing sweep");

endmodule

// File: logic/l1d_pkg.sv
// Common widths, types and opcodes of the L1 data cache.
// Imported by every cache module and by the testbench, so both sides
// agree on the request layout of the core and MAU ports.

package l1d_pkg;

	// ------------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------------
	localparam int CORE_ADDR_WIDTH = 32;
	localparam int CORE_DATA_WIDTH = 32;
	localparam int CORE_BE_WIDTH   = CORE_DATA_WIDTH / 8;
	localparam int CORE_COP_WIDTH  = 2;
	localparam int CORE_SIZE_WIDTH = 3;
	localparam int L1_LINE_WIDTH   = 128;
	localparam int L1_LINE_BYTES   = L1_LINE_WIDTH / 8;
	localparam int L1_OFFSET_WIDTH = 4;
	// Tag width for the default 16 sets
	localparam int L1_TAG_WIDTH    = 24;

	typedef logic [CORE_ADDR_WIDTH-1:0] core_addr_t;
	typedef logic [CORE_DATA_WIDTH-1:0] core_data_t;
	typedef logic [CORE_BE_WIDTH-1:0]   core_be_t;
	typedef logic [CORE_COP_WIDTH-1:0]  core_cop_t;
	typedef logic [CORE_SIZE_WIDTH-1:0] core_size_t;
	typedef logic [L1_LINE_WIDTH-1:0]   l1_line_t;
	typedef logic [L1_LINE_BYTES-1:0]   l1_line_be_t;
	typedef logic [L1_TAG_WIDTH-1:0]    l1_tag_t;

	// Core opcodes
	localparam core_cop_t CORE_REQ_RD   = 2'd0;
	localparam core_cop_t CORE_REQ_WR   = 2'd1;
	localparam core_cop_t CORE_REQ_RDNC = 2'd2;
	localparam core_cop_t CORE_REQ_WRNC = 2'd3;

	// ------------------------------------------------------------------
	// Structures
	// ------------------------------------------------------------------
	typedef struct packed {
		logic    val;
		l1_tag_t tag;
	} l1_ld_entry_t;

	typedef struct packed {
		core_addr_t addr;
		core_cop_t  cop;
		core_data_t wdata;
		core_size_t size;
	} core_req_t;

	// Single-word data sits in the low lanes, be covers one word
	typedef struct packed {
		logic       nc;
		logic       we;
		core_addr_t addr;
		core_data_t wdata;
		core_be_t   be;
	} mau_req_t;

	// Byte enables of a word-aligned access, data in the low bytes
	function automatic core_be_t core_size_be(input core_size_t size);
		case (size)
			3'd1:    return 4'b0001;
			3'd2:    return 4'b0011;
			default: return 4'b1111;
		endcase
	endfunction

endpackage
